// File: Makefile
SIM        := verilator
TOP        := md_unit_tb
RTL_TOP    := md_unit
FILELIST   := list.f
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "\*\*\* PASSED \*\*\*" $(LOG)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: list.f
source/md_pkg.sv
source/md_ifs.sv
source/md_issue.sv
source/md_multiplier.sv
source/md_serdiv.sv
source/md_mult.sv
source/md_result_fifo.sv
source/md_unit.sv
tb/md_unit_tb.sv

// File: source/md_ifs.sv
`timescale 1ns/1ps

// request channel, issue stage to core
interface md_req_if;
  import md_pkg::*;

  logic      valid;
  logic      ready;
  md_op_e    op;
  xlen_t     operand_a;
  xlen_t     operand_b;
  trans_id_t trans_id;

  modport producer (output valid, op, operand_a, operand_b, trans_id, input ready);
  modport core (input valid, op, operand_a, operand_b, trans_id, output ready);
endinterface

// result channel, core to result buffer
interface md_res_if;
  import md_pkg::*;

  logic      valid;
  logic      ready;
  xlen_t     result;
  trans_id_t trans_id;

  modport source (output valid, result, trans_id, input ready);
  modport sink (input valid, result, trans_id, output ready);
endinterface

// File: source/md_issue.sv
`timescale 1ns/1ps

module md_issue #(
  parameter int unsigned Depth = 4
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  md_pkg::md_op_e    req_op_i,
  input  md_pkg::xlen_t     req_a_i,
  input  md_pkg::xlen_t     req_b_i,
  input  md_pkg::trans_id_t req_id_i,
  input  logic              pop_i,
  md_req_if.producer        req_o
);
  import md_pkg::*;

  localparam int unsigned CntW = $clog2(Depth + 1);

  logic [CntW-1:0] cnt_q;
  logic [CntW-1:0] cnt_d;
  logic            credit_ok;
  logic            accept;

  // back-to-back multiplies need one slot per pipeline stage
  if (Depth < MUL_LATENCY) begin : g_depth_check
    $error("md_issue: Depth is smaller than the multiplier latency");
  end

  // --------------------------------------------------
  // credit gate
  // --------------------------------------------------
  // one credit per result buffer entry
  assign credit_ok = (cnt_q < CntW'(Depth));

  // the core only sees requests that already own a credit
  assign req_o.valid     = req_valid_i & credit_ok;
  assign req_o.op        = req_op_i;
  assign req_o.operand_a = req_a_i;
  assign req_o.operand_b = req_b_i;
  assign req_o.trans_id  = req_id_i;

  assign req_ready_o = req_o.ready & credit_ok;
  assign accept      = req_valid_i & req_ready_o;

  // --------------------------------------------------
  // outstanding operation counter
  // --------------------------------------------------
  always_comb begin
    cnt_d = cnt_q;
    case ({accept, pop_i})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // never more in flight than the buffer can hold
  assert property (@(posedge clk_i) disable iff (!rst_ni) cnt_q <= CntW'(Depth));
  // every pop at the top level belongs to an operation issued here
  assert property (@(posedge clk_i) disable iff (!rst_ni) pop_i |-> cnt_q != '0);

endmodule

// File: source/md_mult.sv
`timescale 1ns/1ps

module md_mult (
  input  logic     clk_i,
  input  logic     rst_ni,
  md_req_if.core   req_i,
  md_res_if.source res_o
);
  import md_pkg::*;

  logic      is_mul;
  logic      mul_valid_op;
  logic      div_valid_op;
  logic      div_in_ready;
  logic      div_out_ready;
  logic      div_signed;
  logic      div_rem;
  xlen_t     mul_a;
  xlen_t     mul_b;
  xlen_t     div_a;
  xlen_t     div_b;
  logic      mul_valid;
  xlen_t     mul_result;
  trans_id_t mul_id;
  logic      div_valid;
  xlen_t     div_result;
  trans_id_t div_id;

  // --------------------------------------------------
  // input decode
  // --------------------------------------------------
  assign is_mul       = is_mul_op(req_i.op);
  assign mul_valid_op = req_i.valid & is_mul;
  assign div_valid_op = req_i.valid & ~is_mul;
  // multiplier never stalls, divider takes one op at a time
  assign req_i.ready  = is_mul | div_in_ready;

  // divider control from funct3
  assign div_signed = req_i.op inside {DIV, REM};
  assign div_rem    = req_i.op inside {REM, REMU};

  // keep the unused unit's operands quiet
  assign mul_a = is_mul ? req_i.operand_a : '0;
  assign mul_b = is_mul ? req_i.operand_b : '0;
  assign div_a = is_mul ? '0 : req_i.operand_a;
  assign div_b = is_mul ? '0 : req_i.operand_b;

  md_multiplier md_multiplier_i (
    .clk_i,
    .rst_ni,
    .valid_i  (mul_valid_op),
    .op_i     (req_i.op),
    .a_i      (mul_a),
    .b_i      (mul_b),
    .id_i     (req_i.trans_id),
    .valid_o  (mul_valid),
    .result_o (mul_result),
    .id_o     (mul_id)
  );

  md_serdiv md_serdiv_i (
    .clk_i,
    .rst_ni,
    .in_valid_i  (div_valid_op),
    .signed_i    (div_signed),
    .rem_i       (div_rem),
    .a_i         (div_a),
    .b_i         (div_b),
    .id_i        (req_i.trans_id),
    .out_ready_i (div_out_ready),
    .in_ready_o  (div_in_ready),
    .out_valid_o (div_valid),
    .result_o    (div_result),
    .id_o        (div_id)
  );

  // --------------------------------------------------
  // output arbitration
  // --------------------------------------------------
  // multiplier first, the divider can hold its result
  assign div_out_ready  = res_o.ready & ~mul_valid;
  assign res_o.valid    = mul_valid | div_valid;
  assign res_o.result   = mul_valid ? mul_result : div_result;
  assign res_o.trans_id = mul_valid ? mul_id : div_id;

  // credits guarantee room for every multiply result
  assert property (@(posedge clk_i) disable iff (!rst_ni) mul_valid |-> res_o.ready);
  // fixed latency with the tag carried along
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    mul_valid_op |-> ##MUL_LATENCY
      (res_o.valid && res_o.trans_id == $past(req_i.trans_id, MUL_LATENCY)));

endmodule

// File: source/md_multiplier.sv
`timescale 1ns/1ps

module md_multiplier (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              valid_i,
  input  md_pkg::md_op_e    op_i,
  input  md_pkg::xlen_t     a_i,
  input  md_pkg::xlen_t     b_i,
  input  md_pkg::trans_id_t id_i,
  output logic              valid_o,
  output md_pkg::xlen_t     result_o,
  output md_pkg::trans_id_t id_o
);
  import md_pkg::*;

  logic                      sign_a;
  logic                      sign_b;
  logic signed [XLEN:0]      a_q;
  logic signed [XLEN:0]      b_q;
  logic                      high_q;
  trans_id_t                 id_q;
  logic                      valid_q;
  logic signed [2*XLEN+1:0]  prod;

  // --------------------------------------------------
  // stage one, operand extension
  // --------------------------------------------------
  // MULH signs both, MULHSU only a, MULHU none
  assign sign_a = op_i inside {MULH, MULHSU};
  assign sign_b = (op_i == MULH);

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      a_q    <= {sign_a & a_i[XLEN-1], a_i};
      b_q    <= {sign_b & b_i[XLEN-1], b_i};
      high_q <= (op_i != MUL);
      id_q   <= id_i;
    end
  end

  // --------------------------------------------------
  // stage two, product and word select
  // --------------------------------------------------
  // 33x33 signed covers all three sign combinations
  assign prod = a_q * b_q;

  always_ff @(posedge clk_i) begin
    if (valid_q) begin
      result_o <= high_q ? prod[2*XLEN-1:XLEN] : prod[XLEN-1:0];
      id_o     <= id_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      valid_o <= 1'b0;
    end else begin
      valid_q <= valid_i;
      valid_o <= valid_q;
    end
  end

endmodule

// File: source/md_pkg.sv
package md_pkg;

  // --------------------------------------------------
  // data path widths
  // --------------------------------------------------
  // one integer register word, rv32 only
  localparam int unsigned XLEN = 32;
  typedef logic [XLEN-1:0] xlen_t;

  // tag that follows an operation from issue to writeback
  localparam int unsigned TRANS_ID_BITS = 3;
  typedef logic [TRANS_ID_BITS-1:0] trans_id_t;

  // --------------------------------------------------
  // operations
  // --------------------------------------------------
  // encoding equals funct3 of the OP/M instructions
  typedef enum logic [2:0] {
    MUL    = 3'b000,
    MULH   = 3'b001,
    MULHSU = 3'b010,
    MULHU  = 3'b011,
    DIV    = 3'b100,
    DIVU   = 3'b101,
    REM    = 3'b110,
    REMU   = 3'b111
  } md_op_e;

  // register stages between multiplier input and result
  localparam int unsigned MUL_LATENCY = 2;

  // width of the divider step counter, one step per quotient bit
  localparam int unsigned DIV_CNT_BITS = $clog2(XLEN);

  // funct3[2] clear selects the multiplier
  function automatic logic is_mul_op(md_op_e op);
    return (op[2] == 1'b0);
  endfunction

endpackage

// File: source/md_result_fifo.sv
`timescale 1ns/1ps

module md_result_fifo #(
  parameter int unsigned Depth = 4
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  md_res_if.sink            res_i,
  input  logic              res_ready_i,
  output logic              res_valid_o,
  output md_pkg::xlen_t     res_data_o,
  output md_pkg::trans_id_t res_id_o
);
  import md_pkg::*;

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  xlen_t           data_mem [Depth];
  trans_id_t       id_mem   [Depth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] cnt_q;
  logic            push;
  logic            pop;

  // --------------------------------------------------
  // handshakes
  // --------------------------------------------------
  assign res_i.ready = (cnt_q != CntW'(Depth));
  assign res_valid_o = (cnt_q != '0);
  assign push        = res_i.valid & res_i.ready;
  assign pop         = res_valid_o & res_ready_i;

  // storage, result and tag side by side
  always_ff @(posedge clk_i) begin
    if (push) begin
      data_mem[wr_ptr_q] <= res_i.result;
      id_mem[wr_ptr_q]   <= res_i.trans_id;
    end
  end

  assign res_data_o = data_mem[rd_ptr_q];
  assign res_id_o   = id_mem[rd_ptr_q];

  // pointers wrap at Depth, which need not be a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop && !push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // the issue credits keep the core from offering a result to a full buffer
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    cnt_q == CntW'(Depth) |-> !res_i.valid);

endmodule

// File: source/md_serdiv.sv
`timescale 1ns/1ps

module md_serdiv (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              in_valid_i,
  input  logic              signed_i,
  input  logic              rem_i,
  input  md_pkg::xlen_t     a_i,
  input  md_pkg::xlen_t     b_i,
  input  md_pkg::trans_id_t id_i,
  input  logic              out_ready_i,
  output logic              in_ready_o,
  output logic              out_valid_o,
  output md_pkg::xlen_t     result_o,
  output md_pkg::trans_id_t id_o
);
  import md_pkg::*;

  typedef enum logic [1:0] {IDLE, DIVIDE, FINISH} state_e;

  state_e                  state_q;
  state_e                  state_d;
  logic [DIV_CNT_BITS-1:0] cnt_q;
  logic [DIV_CNT_BITS-1:0] cnt_d;
  logic                    a_neg;
  logic                    b_neg;
  xlen_t                   a_abs;
  xlen_t                   b_abs;
  logic                    div_zero;
  xlen_t                   quo_q;
  xlen_t                   rem_q;
  xlen_t                   dvs_q;
  logic                    neg_quo_q;
  logic                    neg_rem_q;
  logic                    sel_rem_q;
  trans_id_t               id_q;
  logic [XLEN:0]           rem_shift;
  logic [XLEN:0]           rem_diff;
  xlen_t                   res_mag;
  logic                    res_neg;

  // --------------------------------------------------
  // operand preparation
  // --------------------------------------------------
  assign a_neg    = signed_i & a_i[XLEN-1];
  assign b_neg    = signed_i & b_i[XLEN-1];
  assign a_abs    = a_neg ? -a_i : a_i;
  assign b_abs    = b_neg ? -b_i : b_i;
  assign div_zero = (b_i == '0);

  // restoring step, remainder shifted left by one dividend bit
  assign rem_shift = {rem_q, quo_q[XLEN-1]};
  assign rem_diff  = rem_shift - {1'b0, dvs_q};

  // --------------------------------------------------
  // control FSM
  // --------------------------------------------------
  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    case (state_q)
      IDLE: begin
        if (in_valid_i) begin
          cnt_d = DIV_CNT_BITS'(XLEN - 1);
          // divide by zero skips the loop
          state_d = div_zero ? FINISH : DIVIDE;
        end
      end
      DIVIDE: begin
        cnt_d = cnt_q - 1'b1;
        if (cnt_q == '0) begin
          state_d = FINISH;
        end
      end
      FINISH: begin
        if (out_ready_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // --------------------------------------------------
  // data path
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && in_valid_i) begin
      id_q      <= id_i;
      sel_rem_q <= rem_i;
      dvs_q     <= b_abs;
      if (div_zero) begin
        // quotient all ones, remainder is the dividend
        quo_q     <= '1;
        rem_q     <= a_i;
        neg_quo_q <= 1'b0;
        neg_rem_q <= 1'b0;
      end else begin
        quo_q     <= a_abs;
        rem_q     <= '0;
        // quotient sign from both operands, remainder from the dividend
        neg_quo_q <= a_neg ^ b_neg;
        neg_rem_q <= a_neg;
      end
    end else if (state_q == DIVIDE) begin
      // one quotient bit per cycle into the freed dividend bits
      if (!rem_diff[XLEN]) begin
        rem_q <= rem_diff[XLEN-1:0];
        quo_q <= {quo_q[XLEN-2:0], 1'b1};
      end else begin
        rem_q <= rem_shift[XLEN-1:0];
        quo_q <= {quo_q[XLEN-2:0], 1'b0};
      end
    end
  end

  // sign fix at the output
  // most negative / -1 wraps back to the dividend, remainder stays zero
  assign res_mag = sel_rem_q ? rem_q : quo_q;
  assign res_neg = sel_rem_q ? neg_rem_q : neg_quo_q;

  assign result_o    = res_neg ? -res_mag : res_mag;
  assign id_o        = id_q;
  assign in_ready_o  = (state_q == IDLE);
  assign out_valid_o = (state_q == FINISH);

  // nonzero divisor, one step per quotient bit before the result shows
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    in_valid_i && in_ready_o && !div_zero |-> ##(XLEN+1) out_valid_o);
  // a stalled result holds value and tag
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(result_o) && $stable(id_o));

endmodule

// File: source/md_unit.sv
`timescale 1ns/1ps

module md_unit #(
  parameter int unsigned Depth = 4
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  // request side
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  md_pkg::md_op_e    req_op_i,
  input  md_pkg::xlen_t     req_a_i,
  input  md_pkg::xlen_t     req_b_i,
  input  md_pkg::trans_id_t req_id_i,
  // result side
  output logic              res_valid_o,
  input  logic              res_ready_i,
  output md_pkg::xlen_t     res_data_o,
  output md_pkg::trans_id_t res_id_o
);

  logic pop;

  md_req_if req_if ();
  md_res_if res_if ();

  // writeback took a result, one credit comes back
  assign pop = res_valid_o & res_ready_i;

  md_issue #(
    .Depth (Depth)
  ) md_issue_i (
    .clk_i,
    .rst_ni,
    .req_valid_i,
    .req_ready_o,
    .req_op_i,
    .req_a_i,
    .req_b_i,
    .req_id_i,
    .pop_i (pop),
    .req_o (req_if.producer)
  );

  md_mult md_mult_i (
    .clk_i,
    .rst_ni,
    .req_i (req_if.core),
    .res_o (res_if.source)
  );

  md_result_fifo #(
    .Depth (Depth)
  ) md_result_fifo_i (
    .clk_i,
    .rst_ni,
    .res_i (res_if.sink),
    .res_ready_i,
    .res_valid_o,
    .res_data_o,
    .res_id_o
  );

endmodule

// File: tb/md_testdata.txt
// columns: op (funct3), operand a, operand b, expected result, all hex
// op codes: 0 MUL, 1 MULH, 2 MULHSU, 3 MULHU, 4 DIV, 5 DIVU, 6 REM, 7 REMU
0 00000003 00000007 00000015
0 ffffffff ffffffff 00000001
0 80000000 00000002 00000000
1 ffffffff ffffffff 00000000
1 80000000 80000000 40000000
1 7fffffff 7fffffff 3fffffff
3 ffffffff ffffffff fffffffe
2 ffffffff ffffffff ffffffff
4 00000014 00000006 00000003
0 00001000 00001000 01000000
3 80000000 80000000 40000000
1 12345678 00010000 00001234
4 80000000 ffffffff 80000000
6 80000000 ffffffff 00000000
4 00000064 00000000 ffffffff
6 00000064 00000000 00000064
5 ffffffff 00000000 ffffffff
7 0000abcd 00000000 0000abcd
4 fffffff9 00000002 fffffffd
6 fffffff9 00000002 ffffffff
5 fffffff9 00000002 7ffffffc
7 fffffff9 00000002 00000001
4 00000007 fffffffe fffffffd
6 00000007 fffffffe 00000001
4 fffffff9 fffffffe 00000003
6 fffffff9 fffffffe ffffffff
0 fffffffe 00000003 fffffffa
2 80000000 00000002 ffffffff
2 7fffffff ffffffff 7ffffffe
3 00000002 80000000 00000001
1 ffffffff 00000005 ffffffff
5 80000000 ffffffff 00000000
7 80000000 ffffffff 80000000
4 000003e8 0000000a 00000064
0 0000ffff 0000ffff fffe0001
6 00000000 00000005 00000000
3 0000ffff 00010001 00000000
7 00000064 00000007 00000002

// File: tb/md_unit_tb.sv
`timescale 1ns/1ps

module md_unit_tb;
  import md_pkg::*;

  localparam int DEPTH        = 4;
  localparam int NUM_VEC      = 38;
  // vectors that run with the consumer always ready
  localparam int P1_VEC       = 18;
  localparam int STALL_CYCLES = 200;
  localparam int TIMEOUT      = NUM_VEC * 40 + 200;
  localparam int NUM_TAGS     = 2**TRANS_ID_BITS;

  logic      clk_i;
  logic      rst_ni;
  logic      req_valid_i;
  logic      req_ready_o;
  md_op_e    req_op_i;
  xlen_t     req_a_i;
  xlen_t     req_b_i;
  trans_id_t req_id_i;
  logic      res_valid_o;
  logic      res_ready_i;
  xlen_t     res_data_o;
  trans_id_t res_id_o;

  // four words per vector: op, a, b, expected
  xlen_t     vec_mem [4*NUM_VEC];
  xlen_t     cur_exp;
  int        cur_idx;

  // scoreboard indexed by tag
  logic      pending [NUM_TAGS];
  xlen_t     exp_res [NUM_TAGS];
  md_op_e    exp_op  [NUM_TAGS];
  int        exp_idx [NUM_TAGS];
  int        pend_cnt;
  int        acc_cnt;
  int        pop_cnt;

  // divide ordering state
  logic      order_check;
  logic      div_open;
  logic      div_long;
  trans_id_t div_tag;
  logic      behind_valid;
  trans_id_t behind_tag;
  trans_id_t last_pop_id;
  int        order_checks;
  int        stall_level;

  int        data_errs;
  int        id_errs;
  int        proto_errs;
  int        flow_errs;

  md_unit #(
    .Depth (DEPTH)
  ) md_unit_i (
    .clk_i,
    .rst_ni,
    .req_valid_i,
    .req_ready_o,
    .req_op_i,
    .req_a_i,
    .req_b_i,
    .req_id_i,
    .res_valid_o,
    .res_ready_i,
    .res_data_o,
    .res_id_o
  );

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  // --------------------------------------------------
  // compare helpers
  // --------------------------------------------------
  task automatic check_result(input string name, input xlen_t exp_val, input xlen_t act_val);
    if (act_val !== exp_val) begin
      data_errs++;
      $display("Error %s: expected %h, actual %h", name, exp_val, act_val);
    end
  endtask

  task automatic check_id(input string name, input trans_id_t exp_val,
                          input trans_id_t act_val);
    if (act_val !== exp_val) begin
      id_errs++;
      $display("Error %s: expected tag %0d, actual tag %0d", name, exp_val, act_val);
    end
  endtask

  // marks words the data file did not overwrite
  function automatic xlen_t fill_word(input int addr);
    return 32'hdead0000 ^ xlen_t'(addr);
  endfunction

  // --------------------------------------------------
  // monitor and scoreboard
  // --------------------------------------------------
  always @(posedge clk_i) begin : monitor
    string  name;
    md_op_e op_seen;
    if (!rst_ni) begin
      for (int t = 0; t < NUM_TAGS; t++) begin
        pending[t] = 1'b0;
      end
      pend_cnt     = 0;
      acc_cnt      = 0;
      pop_cnt      = 0;
      div_open     = 1'b0;
      div_long     = 1'b0;
      behind_valid = 1'b0;
      last_pop_id  = '0;
      order_checks = 0;
      data_errs    = 0;
      id_errs      = 0;
      proto_errs   = 0;
    end else begin
      // credits gone, so no request may be taken
      if (pend_cnt == DEPTH && req_ready_o) begin
        proto_errs++;
        $display("request ready is high with %0d results outstanding", pend_cnt);
      end
      if (res_valid_o && pend_cnt == 0) begin
        proto_errs++;
        $display("result valid is high while no request is pending");
      end
      // pops first, a freed divider may take a new op on the same edge
      if (res_valid_o && res_ready_i) begin
        pop_cnt++;
        if (!pending[res_id_o]) begin
          proto_errs++;
          $display("result with tag %0d popped while that tag is not pending", res_id_o);
        end else begin
          op_seen = exp_op[res_id_o];
          name    = $sformatf("vector %0d %s", exp_idx[res_id_o], op_seen.name());
          check_result(name, exp_res[res_id_o], res_data_o);
          if (div_open && res_id_o == div_tag) begin
            // newest multiply behind a long divide leaves just before it
            if (div_long && behind_valid && order_check) begin
              check_id({name, " order"}, behind_tag, last_pop_id);
              order_checks++;
            end
            div_open = 1'b0;
          end
          pending[res_id_o] = 1'b0;
          pend_cnt--;
        end
        last_pop_id = res_id_o;
      end
      if (req_valid_i && req_ready_o) begin
        acc_cnt++;
        if (pending[req_id_i]) begin
          proto_errs++;
          $display("tag %0d issued again before its result came back", req_id_i);
        end
        pending[req_id_i] = 1'b1;
        exp_res[req_id_i] = cur_exp;
        exp_op[req_id_i]  = req_op_i;
        exp_idx[req_id_i] = cur_idx;
        pend_cnt++;
        if (req_op_i inside {DIV, DIVU, REM, REMU}) begin
          div_open     = 1'b1;
          div_tag      = req_id_i;
          div_long     = (req_b_i != '0);
          behind_valid = 1'b0;
        end else if (div_open) begin
          behind_valid = 1'b1;
          behind_tag   = req_id_i;
        end
      end
      if (pend_cnt > DEPTH) begin
        proto_errs++;
        $display("%0d requests outstanding, more than the buffer depth", pend_cnt);
      end
    end
  end

  // --------------------------------------------------
  // consumer, ready high then stalled then random
  // --------------------------------------------------
  initial begin : consumer
    integer seed;
    int     rnd;
    seed        = 32'h4a00;
    res_ready_i = 1'b1;
    order_check = 1'b1;
    stall_level = -1;
    do begin
      @(negedge clk_i);
    end while (acc_cnt < P1_VEC || pop_cnt < P1_VEC);
    @(posedge clk_i);
    res_ready_i <= 1'b0;
    order_check <= 1'b0;
    repeat (STALL_CYCLES) @(posedge clk_i);
    // buffer should now hold exactly Depth results
    @(negedge clk_i);
    stall_level = pend_cnt;
    forever begin
      @(posedge clk_i);
      rnd = $random(seed);
      res_ready_i <= rnd[0];
    end
  end

  // hard limit on run time
  initial begin : watchdog
    repeat (TIMEOUT) @(posedge clk_i);
    $display("timeout: %0d of %0d results came back within %0d cycles",
             pop_cnt, NUM_VEC, TIMEOUT);
    $display("*** FAILED ***");
    $finish;
  end

  // --------------------------------------------------
  // reset, stimulus and closing
  // --------------------------------------------------
  initial begin : run
    trans_id_t tag;
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_op_i    = MUL;
    req_a_i     = '0;
    req_b_i     = '0;
    req_id_i    = '0;
    cur_exp     = '0;
    cur_idx     = 0;
    tag         = '0;
    flow_errs   = 0;
    for (int k = 0; k < 4*NUM_VEC; k++) begin
      vec_mem[k] = fill_word(k);
    end
    $readmemh("tb/md_testdata.txt", vec_mem);
    if (vec_mem[4*NUM_VEC-1] == fill_word(4*NUM_VEC-1)) begin
      flow_errs++;
      $display("test data file is missing or holds fewer than %0d vectors", NUM_VEC);
    end

    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    if (res_valid_o !== 1'b0 || req_ready_o !== 1'b1) begin
      flow_errs++;
      $display("after reset res_valid_o is %b and req_ready_o is %b", res_valid_o, req_ready_o);
    end

    // one vector at a time, next one driven on the accepting edge
    @(posedge clk_i);
    for (int i = 0; i < NUM_VEC; i++) begin
      req_valid_i <= 1'b1;
      req_op_i    <= md_op_e'(vec_mem[4*i][2:0]);
      req_a_i     <= vec_mem[4*i+1];
      req_b_i     <= vec_mem[4*i+2];
      req_id_i    <= tag;
      cur_exp     <= vec_mem[4*i+3];
      cur_idx     <= i;
      tag++;
      do begin
        @(posedge clk_i);
      end while (!(req_valid_i && req_ready_o));
    end
    req_valid_i <= 1'b0;

    while (pop_cnt < NUM_VEC) @(negedge clk_i);
    @(negedge clk_i);
    if (pend_cnt != 0) begin
      flow_errs++;
      $display("%0d results still pending at the end of the run", pend_cnt);
    end
    if (stall_level != DEPTH) begin
      flow_errs++;
      $display("stalled consumer saw %0d results outstanding instead of %0d",
               stall_level, DEPTH);
    end
    if (order_checks == 0) begin
      flow_errs++;
      $display("no multiply issued behind a long divide was seen");
    end

    $display("errors: data %0d, tag %0d, protocol %0d, flow %0d",
             data_errs, id_errs, proto_errs, flow_errs);
    if (data_errs + id_errs + proto_errs + flow_errs == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
